// File: bench/rgvid_video_checker.sv
/* Bound assertions on the video top: beam hold, blanked black and sync placement */
`timescale 1ns/10ps

module rgvid_video_checker(
    input logic             clk,
    input logic             reset,
    input logic             pxl_cen,
    input rgvid_pkg::beam_t beam,
    input logic             lhbl,
    input logic             lvbl,
    input logic             hs,
    input logic             vs,
    input rgvid_pkg::rgb_t  rgb
);

    logic vis_1;
    logic vis_2;

    // Visible flag delayed by two pixel ticks, same depth as the RGB path
    always_ff @(posedge clk) begin
        if (reset) begin
            vis_1 <= 1'b0;
            vis_2 <= 1'b0;
        end else if (pxl_cen) begin
            vis_1 <= lhbl && lvbl;
            vis_2 <= vis_1;
        end
    end

    a_beam_hold: assert property (@(posedge clk) disable iff (reset)
        !pxl_cen |=> $stable(beam))
        else $error("beam moved without a pixel enable");

    a_blank_black: assert property (@(posedge clk) disable iff (reset)
        !vis_2 |-> rgb == '0)
        else $error("rgb not black during delayed blanking");

    a_hs_blank: assert property (@(posedge clk) disable iff (reset)
        hs |-> !lhbl)
        else $error("hs active inside the visible line");

    a_vs_blank: assert property (@(posedge clk) disable iff (reset)
        vs |-> !lvbl)
        else $error("vs active inside the visible frame");

endmodule

// File: bench/rgvid_video_tb.sv
/* Testbench for the video top: memory models, object regions, palette fills
   and a per-pixel reference of the fix, mix and palette rules */
`timescale 1ns/10ps
`include "rgvid_macros.svh"

module rgvid_video_tb;
    import rgvid_pkg::*;

    localparam int ROWS        = 4;
    localparam int FRAME_TICKS = `RGV_HTOTAL * `RGV_VTOTAL;
    // Two frames per row and two clocks per pixel tick
    localparam int CYCLE_LIMIT = ROWS * 2 * FRAME_TICKS * 2 + 200;

    logic                    clk;
    logic                    reset;
    logic                    pxl_cen;
    logic                    pri;
    beam_t                   beam;
    logic                    lhbl;
    logic                    lvbl;
    logic                    hs;
    logic                    vs;
    logic [`RGV_VRAM_AW-1:0] vram_addr;
    fix_entry_u              vram_dout = '0;
    logic [`RGV_ROM_AW-1:0]  fix_addr;
    logic [31:0]             fix_data = '0;
    layer_pxl_t              obj_pxl;
    logic                    pal_cs;
    logic                    pal_we;
    logic [`RGV_PAL_AW-1:0]  cpu_addr;
    pal_entry_t              cpu_din;
    rgb_t                    rgb;

    fix_entry_u  vram_mem [0:(1 << `RGV_VRAM_AW) - 1];
    logic [31:0] rom_mem  [0:(1 << `RGV_ROM_AW) - 1];
    pal_entry_t  pal_ref  [0:(1 << `RGV_PAL_AW) - 1];

    integer seed = 32'hf1d5_6f55;
    int     cycles = 0;
    beam_t  cur;
    beam_t  prev;

    // Test table of name, pri level, object pattern and palette fill
    string names    [ROWS] = '{"fix_only", "obj_under", "obj_over", "pal_rewrite"};
    logic  pri_tab  [ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1};
    int    obj_tab  [ROWS] = '{0, 1, 1, 2};
    int    fill_tab [ROWS] = '{0, 1, 2, 3};

    // Object regions with the second one transparent
    int         reg_h0  [3] = '{4, 20, 30};
    int         reg_h1  [3] = '{18, 28, 46};
    int         reg_v0  [3] = '{2, 10, 16};
    int         reg_v1  [3] = '{12, 20, 31};
    layer_pxl_t reg_pxl [3] = '{8'h35, 8'ha0, 8'h7c};

    rgvid_video DUT(.*);

    bind rgvid_video rgvid_video_checker u_checker(
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen), .beam(beam),
        .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs), .rgb(rgb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memories answer one clock after the address
    always @(negedge clk) begin
        vram_dout <= vram_mem[vram_addr];
        fix_data  <= rom_mem[fix_addr];
    end

    task automatic report_failure();
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    function automatic beam_t next_beam(beam_t b);
        int    h;
        int    v;
        beam_t n;
        h = int'(b.hdump) + 1;
        v = int'(b.vdump);
        if (h == `RGV_HTOTAL) begin
            h = 0;
            v = (v == `RGV_VTOTAL - 1) ? 0 : v + 1;
        end
        n.hdump = 9'(h);
        n.vdump = 8'(v);
        return n;
    endfunction

    function automatic logic [3:0] levels(beam_t b);
        int h;
        int v;
        h = int'(b.hdump);
        v = int'(b.vdump);
        return {h < `RGV_HVIS, v < `RGV_VVIS,
                h >= `RGV_HS_START && h < `RGV_HS_END,
                v >= `RGV_VS_START && v < `RGV_VS_END};
    endfunction

    function automatic logic visible(beam_t b);
        return int'(b.hdump) < `RGV_HVIS && int'(b.vdump) < `RGV_VVIS;
    endfunction

    function automatic layer_pxl_t obj_at(int pat, beam_t b);
        layer_pxl_t p;
        int         h;
        int         v;
        p = '0;
        h = int'(b.hdump);
        v = int'(b.vdump);
        if (pat == 1) begin
            for (int r = 0; r < 3; r++) begin
                if (h >= reg_h0[r] && h < reg_h1[r] && v >= reg_v0[r] && v < reg_v1[r]) begin
                    p = reg_pxl[r];
                end
            end
        end else if (pat == 2) begin
            p.pal = b.vdump[3:0];
            p.col = b.hdump[3:0] ^ {1'b0, b.vdump[2:0]};
        end
        return p;
    endfunction

    // Tile entry at row v/8 and column h/8, nibble 7 - h mod 8 of the ROM row
    function automatic layer_pxl_t fix_at(beam_t b);
        fix_entry_u  e;
        logic [31:0] w;
        logic [2:0]  nib;
        layer_pxl_t  p;
        e     = vram_mem[{b.vdump[7:3], b.hdump[7:3]}];
        w     = rom_mem[{e.f.code, b.vdump[2:0]}];
        nib   = 3'd7 - b.hdump[2:0];
        p.pal = e.f.pal;
        p.col = w[{nib, 2'b00} +: 4];
        return p;
    endfunction

    function automatic pal_idx_t mix(layer_pxl_t f, layer_pxl_t o, logic pr);
        pal_idx_t i;
        i = '0;
        if (o.col != 4'd0 && (pr || f.col == 4'd0)) begin
            i = {1'b1, o};
        end else if (f.col != 4'd0) begin
            i = {1'b0, f};
        end
        return i;
    endfunction

    function automatic logic [7:0] widen5(logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    function automatic rgb_t shade(pal_idx_t i);
        pal_entry_t e;
        rgb_t       c;
        e       = pal_ref[i];
        c.red   = widen5(e.red);
        c.green = widen5(e.green);
        c.blue  = widen5(e.blue);
        return c;
    endfunction

    task automatic check_rgb(string what, rgb_t exp, rgb_t act);
        if (act !== exp) begin
            $display("ERR %s rgb at h=%0d v=%0d expected %h actual %h",
                     what, cur.hdump, cur.vdump, exp, act);
            report_failure();
        end
    endtask

    task automatic check_beam(string what, beam_t exp, beam_t act);
        if (act !== exp) begin
            $display("ERR %s beam expected h=%0d v=%0d actual h=%0d v=%0d",
                     what, exp.hdump, exp.vdump, act.hdump, act.vdump);
            report_failure();
        end
    endtask

    task automatic check_sync(string what, logic [3:0] exp, logic [3:0] act);
        if (act !== exp) begin
            $display("ERR %s lhbl/lvbl/hs/vs at h=%0d v=%0d expected %b actual %b",
                     what, cur.hdump, cur.vdump, exp, act);
            report_failure();
        end
    endtask

    task automatic check_fetch(string what,
                               logic [`RGV_VRAM_AW-1:0] exp_vram,
                               logic [`RGV_ROM_AW-1:0]  exp_rom,
                               logic [`RGV_VRAM_AW-1:0] act_vram,
                               logic [`RGV_ROM_AW-1:0]  act_rom);
        if (act_vram !== exp_vram || act_rom !== exp_rom) begin
            $display("ERR %s vram_addr/fix_addr expected %h/%h actual %h/%h",
                     what, exp_vram, exp_rom, act_vram, act_rom);
            report_failure();
        end
    endtask

    // Palette written with the pixel enable low, so the beam stands still
    task automatic write_palette(int fill);
        pal_entry_t w;
        for (int i = 0; i < (1 << `RGV_PAL_AW); i++) begin
            case (fill)
                1:       w = {1'b0, 5'(i), 5'(i >> 2), 5'(i >> 4)};
                3:       w = {1'b0, 5'h1f - 5'(i), 5'(i * 3), 5'h1f};
                default: w = 16'($random(seed));
            endcase
            @(negedge clk);
            pal_cs     = 1'b1;
            pal_we     = 1'b1;
            cpu_addr   = 9'(i);
            cpu_din    = w;
            pal_ref[i] = w;
        end
        @(negedge clk);
        pal_cs = 1'b0;
        pal_we = 1'b0;
    endtask

    // After one pixel tick RGB shows the pixel one beam step before the tick
    task automatic pixel_tick(string what, int pat, logic pr);
        layer_pxl_t o;
        rgb_t       exp_rgb;
        beam_t      nb;
        @(negedge clk);
        o       = obj_at(pat, cur);
        obj_pxl = o;
        pxl_cen = 1'b1;
        exp_rgb = visible(prev) ? shade(mix(fix_at(prev), o, pr)) : '0;
        nb      = next_beam(cur);
        @(negedge clk);
        pxl_cen = 1'b0;
        prev    = cur;
        cur     = nb;
        check_beam(what, cur, beam);
        check_sync(what, levels(cur), {lhbl, lvbl, hs, vs});
        check_rgb(what, exp_rgb, rgb);
    endtask

    initial begin
        reset    = 1'b1;
        pxl_cen  = 1'b0;
        pri      = 1'b0;
        obj_pxl  = '0;
        pal_cs   = 1'b0;
        pal_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        for (int i = 0; i < (1 << `RGV_VRAM_AW); i++) begin
            vram_mem[i].raw = 16'($random(seed));
        end
        for (int i = 0; i < (1 << `RGV_ROM_AW); i++) begin
            rom_mem[i] = $random(seed);
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Timer restarts one tile before the end of the frame
        cur.hdump  = 9'(`RGV_HTOTAL - 8);
        cur.vdump  = 8'(`RGV_VTOTAL - 1);
        prev       = cur;
        prev.hdump = 9'(`RGV_HTOTAL - 9);
        check_beam("reset", cur, beam);
        check_sync("reset", 4'b0000, {lhbl, lvbl, hs, vs});
        check_fetch("reset", '0, '0, vram_addr, fix_addr);
        check_rgb("reset", '0, rgb);

        for (int r = 0; r < ROWS; r++) begin
            @(negedge clk);
            pri = pri_tab[r];
            write_palette(fill_tab[r]);
            repeat (FRAME_TICKS) pixel_tick(names[r], obj_tab[r], pri_tab[r]);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: common/rgvid_macros.svh
/* Video geometry and memory address widths */
`ifndef RGVID_MACROS_SVH
`define RGVID_MACROS_SVH

// Horizontal geometry in pixels, visible area starts at hdump 0
`define RGV_HTOTAL    64
`define RGV_HVIS      48
`define RGV_HS_START  50
`define RGV_HS_END    54

// Vertical geometry in lines, visible area starts at vdump 0
`define RGV_VTOTAL    40
`define RGV_VVIS      32
`define RGV_VS_START  34
`define RGV_VS_END    37

// 32x32 tile map
`define RGV_VRAM_AW   10
// 4096 tile codes, 8 rows each
`define RGV_ROM_AW    15
`define RGV_PAL_AW    9

`endif

// File: common/rgvid_pkg.sv
/* Shared types for the arcade video pipeline:
   beam position, tile entries, layer pixels, palette words and final colour */
package rgvid_pkg;

    // Beam position as shown by the video timer
    typedef struct packed {
        logic [8:0] hdump;
        logic [7:0] vdump;
    } beam_t;

    // Fix layer tile entry fields
    typedef struct packed {
        logic [ 3:0] pal;
        logic [11:0] code;
    } fix_fields_t;

    // One VRAM word, seen by the CPU as raw data and by the tilemap as fields
    typedef union packed {
        logic [15:0] raw;
        fix_fields_t f;
    } fix_entry_u;

    // Layer pixel, col of zero is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] col;
    } layer_pxl_t;

    // Palette RAM index, upper half of the RAM belongs to objects
    typedef struct packed {
        logic       obj;
        layer_pxl_t pxl;
    } pal_idx_t;

    // Palette word as written by the CPU
    typedef struct packed {
        logic       spare;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } pal_entry_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

// File: filelist.f
+incdir+common
common/rgvid_pkg.sv
rtl/rgvid_vtimer.sv
fix/rgvid_fix_tilemap.sv
rtl/rgvid_colmix.sv
rtl/rgvid_palette.sv
rtl/rgvid_video.sv
bench/rgvid_video_checker.sv
bench/rgvid_video_tb.sv

// File: fix/rgvid_fix_tilemap.sv
/* Fix layer tilemap: fetches the next tile entry and row,
   then shifts out 4-bit pixels, most significant nibble first */
`timescale 1ns/10ps
`include "rgvid_macros.svh"

module rgvid_fix_tilemap(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pxl_cen,
    input  rgvid_pkg::beam_t         beam,
    output logic [`RGV_VRAM_AW-1:0]  vram_addr,
    input  rgvid_pkg::fix_entry_u    vram_dout,
    output logic [`RGV_ROM_AW-1:0]   fix_addr,
    input  logic [31:0]              fix_data,
    output rgvid_pkg::layer_pxl_t    fix_pxl
);
    import rgvid_pkg::*;

    localparam logic [2:0] STEP_VRAM  = 3'd2;
    localparam logic [2:0] STEP_ROM   = 3'd4;
    localparam logic [2:0] STEP_LATCH = 3'd6;
    localparam logic [2:0] STEP_LOAD  = 3'd7;

    logic [ 2:0] phase;
    logic [ 9:0] ahead_h;
    logic [ 8:0] fetch_h;
    logic [ 7:0] fetch_v;
    fix_entry_u  entry;
    logic [31:0] rom_word;
    logic [31:0] shift;
    logic [ 3:0] cur_pal;

    assign phase   = beam.hdump[2:0];
    assign ahead_h = {1'b0, beam.hdump} + 10'd8;

    // Position one tile ahead, wrapping into the next line
    always_comb begin
        if (ahead_h >= 10'(`RGV_HTOTAL)) begin
            fetch_h = 9'(ahead_h - 10'(`RGV_HTOTAL));
            if (beam.vdump == 8'(`RGV_VTOTAL - 1)) begin
                fetch_v = 8'd0;
            end else begin
                fetch_v = beam.vdump + 8'd1;
            end
        end else begin
            fetch_h = ahead_h[8:0];
            fetch_v = beam.vdump;
        end
    end

    // Fetch sequencer for the next tile
    always_ff @(posedge clk) begin
        if (reset) begin
            vram_addr <= '0;
            fix_addr  <= '0;
        end else if (pxl_cen) begin
            if (phase == STEP_VRAM) begin
                // Row then column of the 32x32 map
                vram_addr <= {fetch_v[7:3], fetch_h[7:3]};
            end
            if (phase == STEP_ROM) begin
                fix_addr <= {vram_dout.f.code, fetch_v[2:0]};
            end
        end
    end

    // Staged entry and ROM word wait here while the current tile shifts
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (phase == STEP_ROM) begin
                entry <= vram_dout;
            end
            if (phase == STEP_LATCH) begin
                rom_word <= fix_data;
            end
        end
    end

    // Pixel shifter, loaded at the tile boundary
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (phase == STEP_LOAD) begin
                shift   <= rom_word;
                cur_pal <= entry.f.pal;
            end else begin
                shift <= {shift[27:0], 4'd0};
            end
        end
    end

    // Output register, pixel h is shown while the beam is at h+1
    always_ff @(posedge clk) begin
        if (reset) begin
            fix_pxl <= '0;
        end else if (pxl_cen) begin
            fix_pxl.pal <= cur_pal;
            fix_pxl.col <= shift[31:28];
        end
    end

endmodule

// File: rtl/rgvid_colmix.sv
/* Colour mixer: picks the fix or the object pixel by transparency
   and priority, and forms the palette index */
`timescale 1ns/10ps

module rgvid_colmix(
    input  rgvid_pkg::layer_pxl_t fix_pxl,
    input  rgvid_pkg::layer_pxl_t obj_pxl,
    input  logic                  pri,
    output rgvid_pkg::pal_idx_t   pix_idx
);

    logic fix_opaque;
    logic obj_opaque;
    logic obj_wins;

    assign fix_opaque = fix_pxl.col != 4'd0;
    assign obj_opaque = obj_pxl.col != 4'd0;

    // Objects cover fix when pri is high or fix is see-through
    assign obj_wins = obj_opaque && (pri || !fix_opaque);

    always_comb begin
        pix_idx = '0;
        if (obj_wins) begin
            pix_idx.obj = 1'b1;
            pix_idx.pxl = obj_pxl;
        end else if (fix_opaque) begin
            pix_idx.obj = 1'b0;
            pix_idx.pxl = fix_pxl;
        end
        // Both transparent falls back to palette entry 0
    end

endmodule

// File: rtl/rgvid_palette.sv
/* Palette stage: CPU-written colour RAM, 5 to 8 bit channel
   expansion and black output during blanking */
`timescale 1ns/10ps
`include "rgvid_macros.svh"

module rgvid_palette(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pxl_cen,
    input  logic                    lhbl,
    input  logic                    lvbl,
    input  logic                    pal_cs,
    input  logic                    pal_we,
    input  logic [`RGV_PAL_AW-1:0]  cpu_addr,
    input  rgvid_pkg::pal_entry_t   cpu_din,
    input  rgvid_pkg::pal_idx_t     pix_idx,
    output rgvid_pkg::rgb_t         rgb
);
    import rgvid_pkg::*;

    pal_entry_t pal_ram [0:(1 << `RGV_PAL_AW) - 1];
    pal_entry_t rd_word;
    rgb_t       color;
    logic       vis_d;

    // Replicate the top bits so full scale maps to 8'hff
    function automatic logic [7:0] expand(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // CPU write port, no read-back
    always_ff @(posedge clk) begin
        if (pal_cs && pal_we) begin
            pal_ram[cpu_addr] <= cpu_din;
        end
    end

    assign rd_word = pal_ram[pix_idx];

    assign color.red   = expand(rd_word.red);
    assign color.green = expand(rd_word.green);
    assign color.blue  = expand(rd_word.blue);

    // Blanking registered once here, plus the output register, lags beam by two ticks
    always_ff @(posedge clk) begin
        if (reset) begin
            vis_d <= 1'b0;
            rgb   <= '0;
        end else if (pxl_cen) begin
            vis_d <= lhbl && lvbl;
            if (vis_d) begin
                rgb <= color;
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

// File: rtl/rgvid_video.sv
/* Video subsystem top: timer, fix tilemap, colour mixer and palette in a pixel pipeline */
`timescale 1ns/10ps
`include "rgvid_macros.svh"

module rgvid_video(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pxl_cen,
    input  logic                    pri,
    output rgvid_pkg::beam_t        beam,
    output logic                    lhbl,
    output logic                    lvbl,
    output logic                    hs,
    output logic                    vs,
    output logic [`RGV_VRAM_AW-1:0] vram_addr,
    input  rgvid_pkg::fix_entry_u   vram_dout,
    output logic [`RGV_ROM_AW-1:0]  fix_addr,
    input  logic [31:0]             fix_data,
    input  rgvid_pkg::layer_pxl_t   obj_pxl,
    input  logic                    pal_cs,
    input  logic                    pal_we,
    input  logic [`RGV_PAL_AW-1:0]  cpu_addr,
    input  rgvid_pkg::pal_entry_t   cpu_din,
    output rgvid_pkg::rgb_t         rgb
);
    import rgvid_pkg::*;

    layer_pxl_t fix_pxl;
    pal_idx_t   pix_idx;

    rgvid_vtimer u_vtimer(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl_cen    ( pxl_cen   ),
        .beam       ( beam      ),
        .lhbl       ( lhbl      ),
        .lvbl       ( lvbl      ),
        .hs         ( hs        ),
        .vs         ( vs        )
    );

    rgvid_fix_tilemap u_fix(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl_cen    ( pxl_cen   ),
        .beam       ( beam      ),
        .vram_addr  ( vram_addr ),
        .vram_dout  ( vram_dout ),
        .fix_addr   ( fix_addr  ),
        .fix_data   ( fix_data  ),
        .fix_pxl    ( fix_pxl   )
    );

    rgvid_colmix u_colmix(
        .fix_pxl    ( fix_pxl   ),
        .obj_pxl    ( obj_pxl   ),
        .pri        ( pri       ),
        .pix_idx    ( pix_idx   )
    );

    rgvid_palette u_palette(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .pxl_cen    ( pxl_cen   ),
        .lhbl       ( lhbl      ),
        .lvbl       ( lvbl      ),
        .pal_cs     ( pal_cs    ),
        .pal_we     ( pal_we    ),
        .cpu_addr   ( cpu_addr  ),
        .cpu_din    ( cpu_din   ),
        .pix_idx    ( pix_idx   ),
        .rgb        ( rgb       )
    );

endmodule

// File: rtl/rgvid_vtimer.sv
/* Video timer: pixel and line counters with blanking and sync levels */
`timescale 1ns/10ps
`include "rgvid_macros.svh"

module rgvid_vtimer(
    input  logic             clk,
    input  logic             reset,
    input  logic             pxl_cen,
    output rgvid_pkg::beam_t beam,
    output logic             lhbl,
    output logic             lvbl,
    output logic             hs,
    output logic             vs
);
    import rgvid_pkg::*;

    beam_t nxt;
    logic  line_end;
    logic  frame_end;

    assign line_end  = beam.hdump == 9'(`RGV_HTOTAL - 1);
    assign frame_end = beam.vdump == 8'(`RGV_VTOTAL - 1);

    // Position after the next pixel tick
    always_comb begin
        nxt = beam;
        if (line_end) begin
            nxt.hdump = 9'd0;
            if (frame_end) begin
                nxt.vdump = 8'd0;
            end else begin
                nxt.vdump = beam.vdump + 8'd1;
            end
        end else begin
            nxt.hdump = beam.hdump + 9'd1;
        end
    end

    // Levels come from the next position so they change together with beam
    always_ff @(posedge clk) begin
        if (reset) begin
            // Start one tile before the frame end so the first tile is fetched in time
            beam.hdump <= 9'(`RGV_HTOTAL - 8);
            beam.vdump <= 8'(`RGV_VTOTAL - 1);
            lhbl       <= 1'b0;
            lvbl       <= 1'b0;
            hs         <= 1'b0;
            vs         <= 1'b0;
        end else if (pxl_cen) begin
            beam <= nxt;
            lhbl <= nxt.hdump < 9'(`RGV_HVIS);
            lvbl <= nxt.vdump < 8'(`RGV_VVIS);
            hs   <= nxt.hdump >= 9'(`RGV_HS_START) && nxt.hdump < 9'(`RGV_HS_END);
            vs   <= nxt.vdump >= 8'(`RGV_VS_START) && nxt.vdump < 8'(`RGV_VS_END);
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module rgvid_video_tb -o sim_rgvid

./obj_dir/sim_rgvid > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
